/* Bender.yml */
package:
  name: db_subsys

sources:
  - files:
      - hw/db_pkg.sv
      - hw/db_cmd_decode.sv
      - hw/db_peripheral.sv
      - hw/db_store.sv
      - hw/db_result.sv
      - hw/db_subsys.sv
  - target: test
    files:
      - dv/db_subsys_checker.sv
      - dv/db_subsys_tb.sv

/* db_subsys.f */
hw/db_pkg.sv
hw/db_cmd_decode.sv
hw/db_peripheral.sv
hw/db_store.sv
hw/db_result.sv
hw/db_subsys.sv
dv/db_subsys_checker.sv
dv/db_subsys_tb.sv

/* dv/db_subsys_checker.sv */
module db_peripheral_checker (
    input logic clk,
    input logic srst,
    input logic cmd_rdy,
    input logic done,
    input logic rd_req,
    input logic rd_rdy,
    input logic rd_ack,
    input logic timeout
);

    timeunit 1ns;
    timeprecision 1ps;

    logic rd_open;

    // Read accepted by the store and not yet acknowledged
    always_ff @(posedge clk) begin
        if (srst) begin
            rd_open <= 1'b0;
        end else if (rd_req && rd_rdy) begin
            rd_open <= 1'b1;
        end else if (rd_ack) begin
            rd_open <= 1'b0;
        end
    end

    // A timeout is the only way out of a pending request
    rd_req_held: assert property (@(posedge clk) disable iff (srst)
        rd_req && !rd_rdy && !timeout |=> rd_req)
        else $error("rd_req dropped before the store accepted it");

    done_single: assert property (@(posedge clk) disable iff (srst)
        done |=> !done)
        else $error("done was high in two consecutive cycles");

    rdy_not_done: assert property (@(posedge clk) disable iff (srst)
        !(cmd_rdy && done))
        else $error("cmd_rdy and done were high together");

    ack_has_read: assert property (@(posedge clk) disable iff (srst)
        rd_ack |-> rd_open)
        else $error("rd_ack arrived with no read outstanding");

endmodule : db_peripheral_checker

bind db_peripheral db_peripheral_checker checker_i (
    .clk     (clk),
    .srst    (srst),
    .cmd_rdy (cmd_rdy),
    .done    (done),
    .rd_req  (rd_req),
    .rd_rdy  (rd_rdy),
    .rd_ack  (rd_ack),
    .timeout (timeout)
);

/* dv/db_subsys_tb.sv */
module db_subsys_tb
    import db_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int TIMEOUT_CYCLES = 20;
    localparam int RESET_CYCLES   = 10;
    // About 150 commands at up to 26 cycles each
    localparam int MAX_CYCLES     = 4000;

    logic      clk = 1'b0;
    logic      srst;
    logic      cmd_req;
    logic      cmd_rdy;
    db_cmd_t   cmd;
    logic      resp_valid;
    db_resp_t  resp;
    db_stats_t stats;

    // Model state
    logic               mir_valid [NUM_KEYS];
    logic [VALUE_W-1:0] mir_value [NUM_KEYS];
    int                 ok_tally;
    int                 err_tally;
    int                 to_tally;
    db_resp_t           exp_q [$];
    db_resp_t           last_exp;

    // Bookkeeping
    integer seed = 24978;
    string  test_name;
    int     err_cnt;
    int     test_err_base;
    int     test_cmds;
    int     tests_run;
    int     resp_cnt;
    int     cycle_cnt;

    always #2 clk = ~clk;

    db_subsys dut_i (
        .clk        (clk),
        .srst       (srst),
        .cmd_req    (cmd_req),
        .cmd_rdy    (cmd_rdy),
        .cmd        (cmd),
        .resp_valid (resp_valid),
        .resp       (resp),
        .stats      (stats)
    );

    // ----------------------------------------------------------
    // Reference model
    // ----------------------------------------------------------
    function automatic db_resp_t predict(input db_cmd_t c);
        db_resp_t r;
        int       base;
        int       k;
        int       n;
        logic     found;
        r        = '0;
        r.status = STATUS_OK;
        base     = c.key;
        case (c.command)
            COMMAND_NOP: begin
            end
            COMMAND_CLEAR: begin
                for (k = 0; k < NUM_KEYS; k++) begin
                    mir_valid[k] = 1'b0;
                end
            end
            COMMAND_SET: begin
                mir_valid[base] = 1'b1;
                mir_value[base] = c.set_value;
            end
            COMMAND_GET, COMMAND_REPLACE, COMMAND_UNSET: begin
                // Old entry is reported before any write lands
                r.get_valid = mir_valid[base];
                r.get_key   = c.key;
                r.get_value = mir_value[base];
                if (c.command == COMMAND_REPLACE) begin
                    mir_valid[base] = 1'b1;
                    mir_value[base] = c.set_value;
                end else if (c.command == COMMAND_UNSET) begin
                    mir_valid[base] = 1'b0;
                    mir_value[base] = '0;
                end
            end
            COMMAND_GET_NEXT, COMMAND_UNSET_NEXT: begin
                found = 1'b0;
                k     = base + 1;
                while (k < NUM_KEYS && !found) begin
                    if (mir_valid[k]) begin
                        found = 1'b1;
                    end else begin
                        k++;
                    end
                end
                // Entries visited, one per cycle
                n = found ? k - base : NUM_KEYS - 1 - base;
                if (found) begin
                    r.get_valid = 1'b1;
                    r.get_key   = KEY_W'(k);
                    r.get_value = mir_value[k];
                    if (c.command == COMMAND_UNSET_NEXT) begin
                        mir_valid[k] = 1'b0;
                        mir_value[k] = '0;
                    end
                end
                // Timer stands at n when the scan ends
                if (n >= TIMEOUT_CYCLES - 1) begin
                    r        = '0;
                    r.status = STATUS_TIMEOUT;
                end
            end
            default: begin
                r.status = STATUS_ERROR;
            end
        endcase
        if (r.status == STATUS_OK) ok_tally++;
        else if (r.status == STATUS_ERROR) err_tally++;
        else to_tally++;
        return r;
    endfunction

    function automatic logic [KEY_W-1:0] rand_key();
        logic [31:0] r;
        r = $random(seed);
        return r[KEY_W-1:0];
    endfunction

    function automatic logic [VALUE_W-1:0] rand_value();
        logic [31:0] r;
        r = $random(seed);
        return r[VALUE_W-1:0];
    endfunction

    // ----------------------------------------------------------
    // Driving and comparison
    // ----------------------------------------------------------
    task automatic send_cmd(
        input command_t           code,
        input logic [KEY_W-1:0]   key,
        input logic [VALUE_W-1:0] value
    );
        db_cmd_t c;
        c.command   = code;
        c.key       = key;
        c.set_value = value;
        last_exp    = predict(c);
        exp_q.push_back(last_exp);
        test_cmds++;
        @(posedge clk);
        cmd_req <= 1'b1;
        cmd     <= c;
        @(negedge clk);
        while (!cmd_rdy) @(negedge clk);
        @(posedge clk);
        cmd_req <= 1'b0;
    endtask

    task automatic check_resp(input db_resp_t exp, input db_resp_t act);
        resp_cnt++;
        if (act.status !== exp.status) begin
            $display("CHECK FAILED %s status: expected %0d, actual %0d",
                     test_name, exp.status, act.status);
            err_cnt++;
        end
        if (act.get_valid !== exp.get_valid) begin
            $display("CHECK FAILED %s get_valid: expected %0b, actual %0b",
                     test_name, exp.get_valid, act.get_valid);
            err_cnt++;
        end
        if (exp.get_valid && act.get_key !== exp.get_key) begin
            $display("CHECK FAILED %s get_key: expected %0d, actual %0d",
                     test_name, exp.get_key, act.get_key);
            err_cnt++;
        end
        if (exp.get_valid && act.get_value !== exp.get_value) begin
            $display("CHECK FAILED %s get_value: expected 0x%h, actual 0x%h",
                     test_name, exp.get_value, act.get_value);
            err_cnt++;
        end
    endtask

    task automatic wait_drain();
        while (exp_q.size() != 0) @(negedge clk);
    endtask

    task automatic end_test();
        wait_drain();
        $display("Test %s: %0d commands, %0d errors",
                 test_name, test_cmds, err_cnt - test_err_base);
        tests_run++;
        test_cmds     = 0;
        test_err_base = err_cnt;
    endtask

    // resp_valid lasts one cycle, so one negedge sees it once
    initial begin : compare
        db_resp_t exp;
        forever begin
            @(negedge clk);
            if (resp_valid) begin
                if (exp_q.size() == 0) begin
                    $display("Test %s: response arrived with no command outstanding",
                             test_name);
                    err_cnt++;
                end else begin
                    exp = exp_q.pop_front();
                    check_resp(exp, resp);
                end
            end
        end
    end

    initial begin : watchdog
        cycle_cnt = 0;
        while (cycle_cnt < MAX_CYCLES) begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("Run hung in test %s: still running after %0d cycles",
                 test_name, MAX_CYCLES);
        $display("sim failed");
        $finish;
    end

    // ----------------------------------------------------------
    // Stimulus
    // ----------------------------------------------------------
    initial begin : stimulus
        int               i;
        int               wait_cnt;
        logic [KEY_W-1:0] key;
        srst    = 1'b1;
        cmd_req = 1'b0;
        cmd     = '0;
        for (i = 0; i < NUM_KEYS; i++) begin
            mir_valid[i] = 1'b0;
            mir_value[i] = '0;
        end

        test_name = "reset_nop";
        repeat (RESET_CYCLES - 1) begin
            @(negedge clk);
            if (cmd_rdy !== 1'b0) begin
                $display("Test %s: cmd_rdy was high during reset", test_name);
                err_cnt++;
            end
        end
        @(posedge clk);
        srst <= 1'b0;
        wait_cnt = 0;
        @(negedge clk);
        while (cmd_rdy !== 1'b1 && wait_cnt < 20) begin
            @(negedge clk);
            wait_cnt++;
        end
        if (cmd_rdy !== 1'b1) begin
            $display("Test %s: cmd_rdy did not rise within 20 cycles of reset", test_name);
            err_cnt++;
        end
        send_cmd(COMMAND_NOP, '0, '0);
        end_test();

        test_name = "set_get";
        for (i = 0; i < 16; i++) send_cmd(COMMAND_SET, rand_key(), rand_value());
        for (i = 0; i < NUM_KEYS; i++) send_cmd(COMMAND_GET, KEY_W'(i), '0);
        end_test();

        test_name = "replace_unset";
        for (i = 0; i < 6; i++) begin
            key = rand_key();
            send_cmd(COMMAND_REPLACE, key, rand_value());
            send_cmd(COMMAND_GET, key, '0);
            send_cmd(COMMAND_UNSET, key, '0);
            send_cmd(COMMAND_GET, key, '0);
        end
        end_test();

        // Anchors every 8 keys keep each scan to 8 entries or fewer
        test_name = "get_unset_next";
        for (i = 0; i < 4; i++) send_cmd(COMMAND_SET, KEY_W'(4 + 8 * i), rand_value());
        for (i = 0; i < 10; i++) begin
            key = rand_key();
            send_cmd(COMMAND_GET_NEXT, key, '0);
            send_cmd(COMMAND_UNSET_NEXT, key, '0);
            // Removed entry reads back invalid before it is put back for the anchors
            if (last_exp.get_valid) begin
                key = last_exp.get_key;
                send_cmd(COMMAND_GET, key, '0);
                send_cmd(COMMAND_SET, key, rand_value());
            end
        end
        send_cmd(COMMAND_GET_NEXT, 5'd31, '0);
        end_test();

        test_name = "clear_illegal";
        send_cmd(COMMAND_CLEAR, '0, '0);
        for (i = 0; i < NUM_KEYS; i++) send_cmd(COMMAND_GET, KEY_W'(i), '0);
        send_cmd(command_t'(4'd8), rand_key(), rand_value());
        send_cmd(command_t'(4'd12), rand_key(), rand_value());
        send_cmd(command_t'(4'd15), rand_key(), rand_value());
        end_test();

        // Empty table, so the scan from key 0 visits 31 entries
        test_name = "timeout_stats";
        send_cmd(COMMAND_GET_NEXT, 5'd0, '0);
        send_cmd(COMMAND_SET, 5'd12, rand_value());
        send_cmd(COMMAND_GET, 5'd12, '0);
        send_cmd(COMMAND_GET_NEXT, 5'd0, '0);
        send_cmd(COMMAND_NOP, '0, '0);
        wait_drain();
        if (stats.ok_cnt !== 16'(ok_tally)) begin
            $display("CHECK FAILED %s ok_cnt: expected %0d, actual %0d",
                     test_name, ok_tally, stats.ok_cnt);
            err_cnt++;
        end
        if (stats.err_cnt !== 16'(err_tally)) begin
            $display("CHECK FAILED %s err_cnt: expected %0d, actual %0d",
                     test_name, err_tally, stats.err_cnt);
            err_cnt++;
        end
        if (stats.timeout_cnt !== 16'(to_tally)) begin
            $display("CHECK FAILED %s timeout_cnt: expected %0d, actual %0d",
                     test_name, to_tally, stats.timeout_cnt);
            err_cnt++;
        end
        end_test();

        $display("Summary: %0d tests, %0d responses checked, %0d errors",
                 tests_run, resp_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule : db_subsys_tb

/* hw/db_cmd_decode.sv */
module db_cmd_decode
    import db_pkg::*;
(
    input  db_cmd_t cmd,
    output db_op_t  op
);

    always_comb begin
        // Defaults cover a plain write of set_value
        op.kind     = OP_ILLEGAL;
        op.key      = cmd.key;
        op.rd_next  = 1'b0;
        op.wr_next  = 1'b0;
        op.wr_valid = 1'b1;
        op.wr_value = cmd.set_value;

        case (cmd.command)
            COMMAND_NOP: begin
                op.kind = OP_NOP;
            end
            COMMAND_CLEAR: begin
                op.kind = OP_CLEAR;
            end
            COMMAND_GET: begin
                op.kind = OP_RD;
            end
            COMMAND_GET_NEXT: begin
                op.kind    = OP_RD;
                op.rd_next = 1'b1;
            end
            COMMAND_SET: begin
                op.kind = OP_WR;
            end
            COMMAND_REPLACE: begin
                op.kind = OP_RMW;
            end
            COMMAND_UNSET: begin
                op.kind     = OP_RMW;
                op.wr_valid = 1'b0;
                op.wr_value = '0;
            end
            COMMAND_UNSET_NEXT: begin
                // Write lands on whatever key the scan finds
                op.kind     = OP_RMW;
                op.rd_next  = 1'b1;
                op.wr_next  = 1'b1;
                op.wr_valid = 1'b0;
                op.wr_value = '0;
            end
            default: begin
                op.kind = OP_ILLEGAL;
            end
        endcase
    end

endmodule : db_cmd_decode

/* hw/db_peripheral.sv */
module db_peripheral
    import db_pkg::*;
#(
    parameter int TIMEOUT_CYCLES = 20,
    parameter int INIT_DEBOUNCE  = 8
) (
    input  logic       clk,
    input  logic       srst,

    // Command side
    input  logic       cmd_req,
    output logic       cmd_rdy,
    input  db_op_t     op,
    output logic       done,
    output status_t    status,

    // Store side
    output logic       init,
    input  logic       init_done,
    output logic       rd_req,
    input  logic       rd_rdy,
    input  logic       rd_ack,
    output db_rd_req_t rd,
    output logic       wr_req,
    input  logic       wr_rdy,
    input  logic       wr_ack,
    output db_wr_req_t wr
);

    typedef enum logic [3:0] {
        RESET,
        IDLE,
        CLEAR,
        RD,
        RMW,
        WR,
        CLEAR_PENDING,
        RD_PENDING,
        WR_PENDING,
        DONE,
        ERROR,
        TIMEOUT
    } state_t;

    state_t  state;
    state_t  nxt_state;
    db_op_t  op_q;
    logic    accept;
    logic    finish;
    status_t finish_status;
    logic    reset_timer;
    logic    inc_timer;
    logic    timeout;
    logic    init_ok;

    // ------------------------------------------------------------
    // FSM
    // ------------------------------------------------------------
    // Hold off new commands while the done strobe is out
    assign cmd_rdy = (state == IDLE) && !done;
    assign accept  = cmd_req && cmd_rdy;

    always_ff @(posedge clk) begin
        if (srst) begin
            state <= RESET;
        end else if (timeout) begin
            state <= TIMEOUT;
        end else begin
            state <= nxt_state;
        end
    end

    always_comb begin
        nxt_state     = state;
        reset_timer   = 1'b0;
        inc_timer     = 1'b0;
        init          = 1'b0;
        rd_req        = 1'b0;
        wr_req        = 1'b0;
        finish        = 1'b0;
        finish_status = STATUS_OK;

        case (state)
            RESET: begin
                if (init_ok) nxt_state = IDLE;
            end
            IDLE: begin
                reset_timer = 1'b1;
                if (accept) begin
                    case (op.kind)
                        OP_NOP:   nxt_state = DONE;
                        OP_CLEAR: nxt_state = CLEAR;
                        OP_RD:    nxt_state = RD;
                        OP_RMW:   nxt_state = RMW;
                        OP_WR:    nxt_state = WR;
                        default:  nxt_state = ERROR;
                    endcase
                end
            end
            CLEAR: begin
                inc_timer = 1'b1;
                init      = 1'b1;
                nxt_state = CLEAR_PENDING;
            end
            RD: begin
                inc_timer = 1'b1;
                rd_req    = 1'b1;
                if (rd_rdy) nxt_state = RD_PENDING;
            end
            RMW: begin
                // Each side waits for the other so both go in together
                inc_timer = 1'b1;
                rd_req    = wr_rdy;
                wr_req    = rd_rdy;
                if (rd_rdy && wr_rdy) nxt_state = RD_PENDING;
            end
            WR: begin
                inc_timer = 1'b1;
                wr_req    = 1'b1;
                if (wr_rdy) nxt_state = WR_PENDING;
            end
            CLEAR_PENDING: begin
                inc_timer = 1'b1;
                if (init_ok) nxt_state = DONE;
            end
            RD_PENDING: begin
                inc_timer = 1'b1;
                if (rd_ack) nxt_state = DONE;
            end
            WR_PENDING: begin
                inc_timer = 1'b1;
                if (wr_ack) nxt_state = DONE;
            end
            DONE: begin
                finish    = 1'b1;
                nxt_state = IDLE;
            end
            ERROR: begin
                finish        = 1'b1;
                finish_status = STATUS_ERROR;
                nxt_state     = IDLE;
            end
            TIMEOUT: begin
                finish        = 1'b1;
                finish_status = STATUS_TIMEOUT;
                nxt_state     = IDLE;
            end
            default: begin
                nxt_state = ERROR;
            end
        endcase
    end

    // Registered completion strobe
    always_ff @(posedge clk) begin
        if (srst) begin
            done <= 1'b0;
        end else begin
            done <= finish;
        end
    end

    always_ff @(posedge clk) begin
        status <= finish_status;
    end

    // ------------------------------------------------------------
    // Request fields
    // ------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (accept) op_q <= op;
    end

    assign rd = '{key: op_q.key, next: op_q.rd_next};
    assign wr = '{key: op_q.key, next: op_q.wr_next, valid: op_q.wr_valid,
                  value: op_q.wr_value};

    // ------------------------------------------------------------
    // init_done debounce and cycle timer
    // ------------------------------------------------------------
    if (INIT_DEBOUNCE > 0) begin : g_debounce
        localparam int CNT_W = $clog2(INIT_DEBOUNCE + 1);
        logic [CNT_W-1:0] high_cnt;

        // Count consecutive high cycles, restart on any drop
        always_ff @(posedge clk) begin
            if (srst || init || !init_done) begin
                high_cnt <= '0;
            end else if (high_cnt != CNT_W'(INIT_DEBOUNCE)) begin
                high_cnt <= high_cnt + 1'b1;
            end
        end
        assign init_ok = (high_cnt == CNT_W'(INIT_DEBOUNCE));
    end else begin : g_no_debounce
        assign init_ok = init_done;
    end

    if (TIMEOUT_CYCLES > 0) begin : g_timer
        localparam int TMR_W = $clog2(TIMEOUT_CYCLES + 1);
        logic [TMR_W-1:0] timer;

        always_ff @(posedge clk) begin
            if (srst || reset_timer) begin
                timer <= '0;
            end else if (inc_timer) begin
                timer <= timer + 1'b1;
            end
        end
        // Only fires in working states, so TIMEOUT itself moves on
        assign timeout = inc_timer && (timer == TMR_W'(TIMEOUT_CYCLES - 1));
    end else begin : g_no_timer
        assign timeout = 1'b0;
    end

endmodule : db_peripheral

/* hw/db_pkg.sv */
package db_pkg;

    // ------------------------------------------------------------
    // Widths
    // ------------------------------------------------------------
    localparam int KEY_W    = 5;
    localparam int NUM_KEYS = 32;
    localparam int VALUE_W  = 16;

    // ------------------------------------------------------------
    // Encodings
    // ------------------------------------------------------------
    // Codes 8 to 15 are illegal
    typedef enum logic [3:0] {
        COMMAND_NOP        = 4'd0,
        COMMAND_CLEAR      = 4'd1,
        COMMAND_GET        = 4'd2,
        COMMAND_GET_NEXT   = 4'd3,
        COMMAND_SET        = 4'd4,
        COMMAND_REPLACE    = 4'd5,
        COMMAND_UNSET      = 4'd6,
        COMMAND_UNSET_NEXT = 4'd7
    } command_t;

    typedef enum logic [1:0] {
        STATUS_OK      = 2'd0,
        STATUS_ERROR   = 2'd1,
        STATUS_TIMEOUT = 2'd2
    } status_t;

    typedef enum logic [2:0] {
        OP_NOP,
        OP_CLEAR,
        OP_RD,
        OP_RMW,
        OP_WR,
        OP_ILLEGAL
    } op_kind_t;

    // ------------------------------------------------------------
    // Structs
    // ------------------------------------------------------------
    typedef struct packed {
        command_t           command;
        logic [KEY_W-1:0]   key;
        logic [VALUE_W-1:0] set_value;
    } db_cmd_t;

    typedef struct packed {
        op_kind_t           kind;
        logic [KEY_W-1:0]   key;
        logic               rd_next;
        logic               wr_next;
        logic               wr_valid;
        logic [VALUE_W-1:0] wr_value;
    } db_op_t;

    typedef struct packed {
        logic [KEY_W-1:0] key;
        logic             next;
    } db_rd_req_t;

    typedef struct packed {
        logic [KEY_W-1:0]   key;
        logic               next;
        logic               valid;
        logic [VALUE_W-1:0] value;
    } db_wr_req_t;

    typedef struct packed {
        logic               valid;
        logic [VALUE_W-1:0] value;
        logic [KEY_W-1:0]   next_key;
    } db_rd_resp_t;

    typedef struct packed {
        status_t            status;
        logic               get_valid;
        logic [KEY_W-1:0]   get_key;
        logic [VALUE_W-1:0] get_value;
    } db_resp_t;

    typedef struct packed {
        logic [15:0] ok_cnt;
        logic [15:0] err_cnt;
        logic [15:0] timeout_cnt;
    } db_stats_t;

endpackage : db_pkg

/* hw/db_result.sv */
module db_result
    import db_pkg::*;
(
    input  logic        clk,
    input  logic        srst,
    input  logic        done,
    input  status_t     status,
    input  logic        rd_ack,
    input  db_rd_resp_t rd_resp,
    output logic        resp_valid,
    output db_resp_t    resp,
    output db_stats_t   stats
);

    db_rd_resp_t cap_q;
    logic        cap_vld;

    // Lookup capture, dropped once the response is out
    always_ff @(posedge clk) begin
        if (srst) begin
            cap_vld <= 1'b0;
        end else if (rd_ack) begin
            cap_vld <= 1'b1;
        end else if (done) begin
            cap_vld <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_ack) cap_q <= rd_resp;
    end

    // Get fields read as zero when no lookup came back
    always_ff @(posedge clk) begin
        if (done) begin
            resp.status    <= status;
            resp.get_valid <= cap_vld && cap_q.valid;
            resp.get_key   <= cap_vld ? cap_q.next_key : '0;
            resp.get_value <= cap_vld ? cap_q.value : '0;
        end
    end

    always_ff @(posedge clk) begin
        if (srst) begin
            resp_valid <= 1'b0;
            stats      <= '0;
        end else begin
            resp_valid <= done;
            if (done) begin
                case (status)
                    STATUS_OK:      stats.ok_cnt      <= stats.ok_cnt + 1'b1;
                    STATUS_TIMEOUT: stats.timeout_cnt <= stats.timeout_cnt + 1'b1;
                    default:        stats.err_cnt     <= stats.err_cnt + 1'b1;
                endcase
            end
        end
    end

endmodule : db_result

/* hw/db_store.sv */
module db_store
    import db_pkg::*;
(
    input  logic        clk,
    input  logic        srst,

    input  logic        init,
    output logic        init_done,

    input  logic        rd_req,
    output logic        rd_rdy,
    input  db_rd_req_t  rd,
    output logic        rd_ack,
    output db_rd_resp_t rd_resp,

    input  logic        wr_req,
    output logic        wr_rdy,
    input  db_wr_req_t  wr,
    output logic        wr_ack
);

    logic [NUM_KEYS-1:0] valid_q;
    logic [VALUE_W-1:0]  value_q [NUM_KEYS];
    logic                clr_q;
    logic                rd_act;
    logic                wr_act;
    logic                busy;
    db_rd_req_t          rd_q;
    db_wr_req_t          wr_q;

    // Scan pointer, one bit wider so key 31 can look past the end
    logic [KEY_W:0]      ptr;
    logic [KEY_W-1:0]    idx;
    logic [KEY_W-1:0]    wr_key;
    logic                past_end;
    logic                hit;
    logic                rd_end;
    logic                wr_en;

    // ------------------------------------------------------------
    // Lookup
    // ------------------------------------------------------------
    assign idx      = rd_q.next ? ptr[KEY_W-1:0] : rd_q.key;
    assign past_end = rd_q.next && ptr[KEY_W];
    assign hit      = !past_end && valid_q[idx];

    // Direct reads end at once, scans on a hit or at the top key
    assign rd_end = !rd_q.next || past_end || hit ||
                    (ptr == (KEY_W + 1)'(NUM_KEYS - 1));

    assign rd_resp.valid    = hit;
    assign rd_resp.value    = value_q[idx];
    assign rd_resp.next_key = (rd_q.next && !hit) ? '0 : idx;

    // ------------------------------------------------------------
    // Handshake
    // ------------------------------------------------------------
    assign busy      = rd_act || wr_act;
    assign rd_rdy    = !busy;
    assign wr_rdy    = !busy;
    assign rd_ack    = rd_act && rd_end;
    // A paired write waits for its read to resolve
    assign wr_ack    = wr_act && (!rd_act || rd_end);
    assign init_done = !clr_q;

    assign wr_key = wr_q.next ? idx : wr_q.key;
    // Nothing found by the scan means nothing to write
    assign wr_en  = wr_ack && (!wr_q.next || (rd_act && hit));

    always_ff @(posedge clk) begin
        if (srst) begin
            rd_act  <= 1'b0;
            wr_act  <= 1'b0;
            clr_q   <= 1'b1;
            valid_q <= '0;
        end else begin
            clr_q <= init;

            if (rd_req && rd_rdy) begin
                rd_act <= 1'b1;
            end else if (rd_ack) begin
                rd_act <= 1'b0;
            end

            if (wr_req && wr_rdy) begin
                wr_act <= 1'b1;
            end else if (wr_ack) begin
                wr_act <= 1'b0;
            end

            if (init) begin
                valid_q <= '0;
            end else if (wr_en) begin
                valid_q[wr_key] <= wr_q.valid;
            end
        end
    end

    // ------------------------------------------------------------
    // Request and table payload
    // ------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (rd_req && rd_rdy) begin
            rd_q <= rd;
            ptr  <= {1'b0, rd.key} + 1'b1;
        end else if (rd_act && !rd_end) begin
            ptr <= ptr + 1'b1;
        end

        if (wr_req && wr_rdy) wr_q <= wr;

        if (wr_en) value_q[wr_key] <= wr_q.value;
    end

endmodule : db_store

/* hw/db_subsys.sv */
module db_subsys
    import db_pkg::*;
#(
    parameter int TIMEOUT_CYCLES = 20,
    parameter int INIT_DEBOUNCE  = 8
) (
    input  logic      clk,
    input  logic      srst,
    input  logic      cmd_req,
    output logic      cmd_rdy,
    input  db_cmd_t   cmd,
    output logic      resp_valid,
    output db_resp_t  resp,
    output db_stats_t stats
);

    db_op_t      op;
    logic        init;
    logic        init_done;
    logic        rd_req;
    logic        rd_rdy;
    logic        rd_ack;
    db_rd_req_t  rd;
    db_rd_resp_t rd_resp;
    logic        wr_req;
    logic        wr_rdy;
    logic        wr_ack;
    db_wr_req_t  wr;
    logic        done;
    status_t     status;

    db_cmd_decode decode_i (
        .cmd (cmd),
        .op  (op)
    );

    db_peripheral #(
        .TIMEOUT_CYCLES (TIMEOUT_CYCLES),
        .INIT_DEBOUNCE  (INIT_DEBOUNCE)
    ) periph_i (
        .clk       (clk),
        .srst      (srst),
        .cmd_req   (cmd_req),
        .cmd_rdy   (cmd_rdy),
        .op        (op),
        .done      (done),
        .status    (status),
        .init      (init),
        .init_done (init_done),
        .rd_req    (rd_req),
        .rd_rdy    (rd_rdy),
        .rd_ack    (rd_ack),
        .rd        (rd),
        .wr_req    (wr_req),
        .wr_rdy    (wr_rdy),
        .wr_ack    (wr_ack),
        .wr        (wr)
    );

    db_store store_i (
        .clk       (clk),
        .srst      (srst),
        .init      (init),
        .init_done (init_done),
        .rd_req    (rd_req),
        .rd_rdy    (rd_rdy),
        .rd        (rd),
        .rd_ack    (rd_ack),
        .rd_resp   (rd_resp),
        .wr_req    (wr_req),
        .wr_rdy    (wr_rdy),
        .wr        (wr),
        .wr_ack    (wr_ack)
    );

    db_result result_i (
        .clk        (clk),
        .srst       (srst),
        .done       (done),
        .status     (status),
        .rd_ack     (rd_ack),
        .rd_resp    (rd_resp),
        .resp_valid (resp_valid),
        .resp       (resp),
        .stats      (stats)
    );

endmodule : db_subsys
